// ==== build.f ====
+incdir+include
source/isa_pkg.sv
source/issue_pkg.sv
source/dispatcher.sv
source/issue_queue.sv
source/issue_stage.sv
testbench/tb_issue_stage.sv

// ==== Makefile ====
# Verilator flow for the issue stage

VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= tb_issue_stage
RTL_TOP   ?= issue_stage
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Regression passed

SIM_BIN = $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# the run passes only when the pass message shows up in its output
sim: build
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_cfg.svh"

module tb_issue_stage;
    import isa_pkg::*;
    import issue_pkg::*;

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_LIMIT  = 200;
    localparam int STREAM_LEN   = 40;
    localparam int DEPTH        = `ISSUE_QUEUE_DEPTH;

    logic       clk;
    logic       rst;
    logic       flush;
    logic       push;
    inst_t      push_inst;
    logic       full;
    lane_slot_t lane_a;
    lane_slot_t lane_b;

    // model queue of entries the dispatcher can already see
    inst_t model_q[$];
    inst_t pending_inst;
    bit    pending_valid;
    int    issue_total;
    int    pair_total;

    issue_stage DUT (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .push      (push),
        .push_inst (push_inst),
        .full      (full),
        .lane_a    (lane_a),
        .lane_b    (lane_b)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    function automatic op_class_t op_class_field(input inst_t inst);
        return op_class_t'(inst.ctrl[`ISSUE_CLASS_LSB +: `ISSUE_CLASS_W]);
    endfunction

    function automatic bit counts_as_arith(input op_class_t cls);
        case (cls)
            OP_ALU, OP_MUL, OP_DIV: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // every register field takes part whether the op uses it or not
    function automatic bit has_dependence(input inst_t o, input inst_t y);
        return (o.rd == y.rd) || (o.rd == y.rj) || (o.rd == y.rk) ||
               (y.rd == o.rj) || (y.rd == o.rk);
    endfunction

    function automatic inst_t make_inst(input op_class_t cls, input int rd, input int rj,
                                        input int rk);
        inst_t inst;
        inst.rd       = reg_idx_t'(rd);
        inst.rj       = reg_idx_t'(rj);
        inst.rk       = reg_idx_t'(rk);
        inst.imm      = imm_t'($urandom);
        inst.ctrl     = ctrl_t'($urandom);
        inst.ctrl[`ISSUE_CLASS_LSB +: `ISSUE_CLASS_W] = cls;
        inst.excp_arg = excp_arg_t'($urandom);
        return inst;
    endfunction

    function automatic inst_t random_inst();
        op_class_t cls;
        int        rd;
        int        rj;
        int        rk;
        cls = op_class_t'(4'($urandom % 6));
        rd  = int'($urandom % 32);
        rj  = int'($urandom % 32);
        rk  = int'($urandom % 32);
        return make_inst(cls, rd, rj, rk);
    endfunction

    // expected lanes from the two oldest model entries before they retire
    task automatic check_lanes();
        lane_slot_t exp_a;
        lane_slot_t exp_b;
        inst_t      o;
        inst_t      y;
        bit         two_seen;
        bit         indep;
        int         retire;
        exp_a    = '0;
        exp_b    = '0;
        retire   = 0;
        two_seen = (model_q.size() > 1);
        if (model_q.size() > 0) begin
            o     = model_q[0];
            y     = two_seen ? model_q[1] : '0;
            indep = two_seen && !has_dependence(o, y);
            if (indep && counts_as_arith(op_class_field(y))) begin
                exp_a  = {1'b1, y};
                exp_b  = {1'b1, o};
                retire = 2;
            end else if (indep && op_class_field(y) == OP_MEM &&
                         counts_as_arith(op_class_field(o))) begin
                exp_a  = {1'b1, o};
                exp_b  = {1'b1, y};
                retire = 2;
            end else begin
                exp_b  = {1'b1, o};
                retire = 1;
            end
        end
        check_equal(128'(lane_a), 128'(exp_a), "lane a slot");
        check_equal(128'(lane_b), 128'(exp_b), "lane b slot");
        repeat (retire) model_q.delete(0);
        issue_total += retire;
        if (retire == 2) begin
            pair_total++;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        check_lanes();
        // a push from the last edge becomes visible to the dispatcher now
        if (pending_valid) begin
            model_q.push_back(pending_inst);
            pending_valid = 1'b0;
        end
        check_equal(128'(full), 128'(model_q.size() == DEPTH), "full level");
        push  = 1'b0;
        flush = 1'b0;
    endtask

    task automatic drive_push(input inst_t inst);
        push      = 1'b1;
        push_inst = inst;
        if (model_q.size() < DEPTH) begin
            pending_inst  = inst;
            pending_valid = 1'b1;
        end
        next_cycle();
    endtask

    task automatic drive_flush();
        flush = 1'b1;
        model_q.delete();
        pending_valid = 1'b0;
        next_cycle();
    endtask

    task automatic wait_drain(input string what);
        int cycles;
        cycles = 0;
        while (model_q.size() != 0) begin
            if (cycles == DRAIN_LIMIT) begin
                $display("timeout: the queue did not drain during %s within %0d cycles",
                         what, DRAIN_LIMIT);
                $display("Regression failed");
                $fatal(1, "drain timeout");
            end
            next_cycle();
            cycles++;
        end
        // lanes must read empty for one quiet cycle
        next_cycle();
    endtask

    // only valid on an empty queue
    task automatic push_with_latency_check(input inst_t inst);
        drive_push(inst);
        check_equal(128'(lane_b.valid), 128'(1'b0), "lane b valid one edge after push");
        next_cycle();
        check_equal(128'(lane_b.valid), 128'(1'b1), "lane b valid two edges after push");
        check_equal(128'(lane_b.inst), 128'(inst), "lane b instruction");
        check_equal(128'(lane_a.valid), 128'(1'b0), "lane a valid on single issue");
    endtask

    task automatic push_pair(input inst_t o, input inst_t y, input string what);
        drive_push(o);
        drive_push(y);
        wait_drain(what);
    endtask

    task automatic test_reset_and_first_issue();
        check_equal(128'(lane_a.valid), 128'(1'b0), "lane a valid after reset");
        check_equal(128'(lane_b.valid), 128'(1'b0), "lane b valid after reset");
        check_equal(128'(full), 128'(1'b0), "full after reset");
        push_with_latency_check(make_inst(OP_ALU, 1, 2, 3));
        wait_drain("first issue");
    endtask

    task automatic test_natural_pair();
        push_pair(make_inst(OP_ALU, 4, 5, 6), make_inst(OP_MUL, 9, 7, 8), "natural pair");
    endtask

    task automatic test_swapped_pair();
        push_pair(make_inst(OP_DIV, 4, 5, 6), make_inst(OP_MEM, 9, 7, 8), "swapped pair");
    endtask

    task automatic test_single_issue();
        // one pair per register match
        push_pair(make_inst(OP_ALU, 4, 5, 6), make_inst(OP_MUL, 4, 7, 8), "rd on rd");
        push_pair(make_inst(OP_ALU, 4, 5, 6), make_inst(OP_MUL, 9, 4, 8), "rd on rj");
        push_pair(make_inst(OP_ALU, 4, 5, 6), make_inst(OP_MUL, 9, 7, 4), "rd on rk");
        push_pair(make_inst(OP_ALU, 4, 5, 6), make_inst(OP_DIV, 5, 7, 8), "rj on rd");
        push_pair(make_inst(OP_ALU, 4, 5, 6), make_inst(OP_DIV, 6, 7, 8), "rk on rd");
        push_pair(make_inst(OP_ALU, 4, 5, 6), make_inst(OP_BRANCH, 9, 7, 8), "branch");
        push_pair(make_inst(OP_MUL, 4, 5, 6), make_inst(OP_CSR, 9, 7, 8), "csr");
        push_pair(make_inst(OP_MEM, 4, 5, 6), make_inst(OP_MEM, 9, 7, 8), "mem on mem");
    endtask

    task automatic test_fill_and_stream();
        // one push more than the queue holds
        for (int i = 0; i <= DEPTH; i++) begin
            drive_push(random_inst());
        end
        for (int i = 0; i < STREAM_LEN; i++) begin
            drive_push(random_inst());
            if ($urandom % 4 == 0) begin
                next_cycle();
            end
        end
        wait_drain("random stream");
    endtask

    task automatic test_flush();
        drive_push(make_inst(OP_ALU, 1, 2, 3));
        drive_push(make_inst(OP_MEM, 4, 5, 6));
        drive_push(make_inst(OP_DIV, 7, 8, 9));
        drive_flush();
        check_equal(128'(lane_a.valid), 128'(1'b0), "lane a valid after flush");
        check_equal(128'(lane_b.valid), 128'(1'b0), "lane b valid after flush");
        check_equal(128'(full), 128'(1'b0), "full after flush");
        push_with_latency_check(make_inst(OP_MUL, 10, 11, 12));
        wait_drain("restart after flush");
    endtask

    initial begin
        void'($urandom(20));
        rst           = 1'b1;
        flush         = 1'b0;
        push          = 1'b0;
        push_inst     = '0;
        pending_inst  = '0;
        pending_valid = 1'b0;
        issue_total   = 0;
        pair_total    = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset_and_first_issue();
        test_natural_pair();
        test_swapped_pair();
        test_single_issue();
        test_fill_and_stream();
        test_flush();

        $display("issued %0d instructions, %0d pair issues", issue_total, pair_total);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  push,
    input  isa_pkg::inst_t        push_inst,
    output logic                  full,
    output issue_pkg::lane_slot_t lane_a,
    output issue_pkg::lane_slot_t lane_b
);
    import issue_pkg::*;

    lane_slot_t older;
    lane_slot_t younger;
    lane_slot_t steer_a;
    lane_slot_t steer_b;
    logic       issue_older;
    logic       issue_younger;

    issue_queue u_queue (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .push        (push),
        .push_inst   (push_inst),
        .pop_older   (issue_older),
        .pop_younger (issue_younger),
        .older       (older),
        .younger     (younger),
        .full        (full)
    );

    dispatcher u_dispatcher (
        .older         (older),
        .younger       (younger),
        .steer_a       (steer_a),
        .steer_b       (steer_b),
        .issue_older   (issue_older),
        .issue_younger (issue_younger)
    );

    // issue registers, always accepted downstream
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            lane_a <= '0;
            lane_b <= '0;
        end else begin
            lane_a <= steer_a;
            lane_b <= steer_b;
        end
    end

endmodule

`default_nettype wire

// ==== source/issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_cfg.svh"

module issue_queue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  push,
    input  isa_pkg::inst_t        push_inst,
    input  logic                  pop_older,
    input  logic                  pop_younger,
    output issue_pkg::lane_slot_t older,
    output issue_pkg::lane_slot_t younger,
    output logic                  full
);
    import isa_pkg::*;
    import issue_pkg::*;

    localparam int DEPTH = `ISSUE_QUEUE_DEPTH;

    inst_t  mem [DEPTH];
    q_ptr_t head;
    q_ptr_t tail;
    q_ptr_t head_next;
    q_cnt_t count;
    q_cnt_t pop_num;
    logic   do_push;
    logic   do_pop_older;
    logic   do_pop_younger;

    assign full = (count == q_cnt_t'(DEPTH));

    // two oldest entries, valid by occupancy
    assign head_next     = head + q_ptr_t'(1);
    assign older.valid   = (count != '0);
    assign older.inst    = mem[head];
    assign younger.valid = (count > q_cnt_t'(1));
    assign younger.inst  = mem[head_next];

    // younger pop only counts together with the older one
    assign do_pop_older   = pop_older & older.valid;
    assign do_pop_younger = do_pop_older & pop_younger & younger.valid;
    assign pop_num        = q_cnt_t'(do_pop_older) + q_cnt_t'(do_pop_younger);

    // push while full or during a flush is dropped
    assign do_push = push & ~full & ~flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + q_ptr_t'(pop_num);
            count <= count + q_cnt_t'(do_push) - pop_num;
            if (do_push) begin
                tail <= tail + q_ptr_t'(1);
            end
        end
    end

    // storage only, entries are qualified by count
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[tail] <= push_inst;
        end
    end

endmodule

`default_nettype wire

// ==== source/dispatcher.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_cfg.svh"

module dispatcher (
    input  issue_pkg::lane_slot_t older,
    input  issue_pkg::lane_slot_t younger,
    output issue_pkg::lane_slot_t steer_a,
    output issue_pkg::lane_slot_t steer_b,
    output logic                  issue_older,
    output logic                  issue_younger
);
    import isa_pkg::*;

    op_class_t older_class;
    op_class_t younger_class;
    logic      older_arith;
    logic      younger_arith;
    logic      dependent;
    logic      both_valid;
    logic      natural_pair;
    logic      swapped_pair;

    function automatic op_class_t class_of(input ctrl_t ctrl);
        return op_class_t'(ctrl[`ISSUE_CLASS_LSB +: `ISSUE_CLASS_W]);
    endfunction

    function automatic logic is_arith(input op_class_t cls);
        return cls inside {OP_ALU, OP_MUL, OP_DIV};
    endfunction

    assign older_class   = class_of(older.inst.ctrl);
    assign younger_class = class_of(younger.inst.ctrl);
    assign older_arith   = is_arith(older_class);
    assign younger_arith = is_arith(younger_class);

    // conservative: every register field is compared, used or not
    assign dependent = (older.inst.rd == younger.inst.rd) |
                       (older.inst.rd == younger.inst.rj) |
                       (older.inst.rd == younger.inst.rk) |
                       (younger.inst.rd == older.inst.rj) |
                       (younger.inst.rd == older.inst.rk);

    assign both_valid = older.valid & younger.valid;

    // younger arithmetic goes straight to lane a
    assign natural_pair = both_valid & ~dependent & younger_arith;

    // arithmetic then memory, swap so the memory op lands on lane b
    assign swapped_pair = both_valid & ~dependent & older_arith &
                          (younger_class == OP_MEM);

    always_comb begin
        steer_a       = '0;
        steer_b       = '0;
        issue_older   = 1'b0;
        issue_younger = 1'b0;
        if (natural_pair) begin
            steer_a       = younger;
            steer_b       = older;
            issue_older   = 1'b1;
            issue_younger = 1'b1;
        end else if (swapped_pair) begin
            steer_a       = older;
            steer_b       = younger;
            issue_older   = 1'b1;
            issue_younger = 1'b1;
        end else if (older.valid) begin
            // single issue on the full lane
            steer_b     = older;
            issue_older = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/issue_pkg.sv ====
`default_nettype none

`include "issue_cfg.svh"

package issue_pkg;

    // one issue slot, valid marks an issued instruction
    typedef struct packed {
        logic          valid;
        isa_pkg::inst_t inst;
    } lane_slot_t;

    // index into the queue, wraps on its own
    typedef logic [$clog2(`ISSUE_QUEUE_DEPTH)-1:0] q_ptr_t;

    // occupancy, needs one extra bit for the full case
    typedef logic [$clog2(`ISSUE_QUEUE_DEPTH+1)-1:0] q_cnt_t;

endpackage

`default_nettype wire

// ==== source/isa_pkg.sv ====
`default_nettype none

`include "issue_cfg.svh"

package isa_pkg;

    // architectural register number
    typedef logic [`ISSUE_REG_W-1:0]  reg_idx_t;
    typedef logic [`ISSUE_IMM_W-1:0]  imm_t;

    // decoded control word, class field at the bottom
    typedef logic [`ISSUE_CTRL_W-1:0] ctrl_t;
    typedef logic [`ISSUE_EXCP_W-1:0] excp_arg_t;

    // ALU, MUL and DIV are the arithmetic classes
    typedef enum logic [`ISSUE_CLASS_W-1:0] {
        OP_ALU    = 0,
        OP_BRANCH = 1,
        OP_MUL    = 2,
        OP_CSR    = 3,
        OP_DIV    = 4,
        OP_MEM    = 5
    } op_class_t;

    typedef struct packed {
        reg_idx_t  rd;
        reg_idx_t  rj;
        reg_idx_t  rk;
        imm_t      imm;
        ctrl_t     ctrl;
        excp_arg_t excp_arg;
    } inst_t;

endpackage

`default_nettype wire

// ==== include/issue_cfg.svh ====
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// instruction field widths
`define ISSUE_REG_W   5
`define ISSUE_IMM_W   32
`define ISSUE_CTRL_W  32
`define ISSUE_EXCP_W  16

// issue queue entries, power of two
`define ISSUE_QUEUE_DEPTH 8

// operation class sits in the low bits of the control word
`define ISSUE_CLASS_LSB 0
`define ISSUE_CLASS_W   4

`endif
